/* link_chip.f */
+incdir+hw/
hw/link_chip_pkg.sv
hw/link_stream_if.sv
hw/tag_master.sv
hw/link_endpoint.sv
hw/core_merge.sv
hw/link_chip.sv
sim/tb_clock_gen.sv
sim/link_chip_props.sv
sim/link_chip_tb.sv

/* sim/link_chip_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "link_chip_defines.svh"

module link_chip_tb
  import link_chip_pkg::*;
  ();

  localparam int NUM_ROWS        = 5;
  localparam int DEPTH           = 1 << `LINK_LG_FIFO_DEPTH;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 400;

  typedef struct packed {
    logic [1:0] io_cfg;
    logic [1:0] mem_cfg;
    logic [2:0] merge_cfg;
    logic [3:0] n_io;
    logic [3:0] n_mem;
    logic       rand_ready;
    logic       model_order;
    logic       tag3;
  } test_row_t;

  logic       clk;
  logic       rst_n;
  logic       tag_data;
  logic       tag_en;
  logic       io_v;
  link_data_t io_data;
  logic       io_tkn;
  logic       mem_v;
  link_data_t mem_data;
  logic       mem_tkn;
  logic       core_v;
  link_data_t core_data;
  link_src_e  core_src;
  logic       core_ready;

  test_row_t  rows [0:NUM_ROWS-1];
  link_data_t io_q [$];
  link_data_t mem_q [$];
  link_src_e  order_q [$];
  link_src_e  rr_last = SRC_MEM;
  logic       check_order = 1'b0;
  int         seed;
  int         io_credit = DEPTH;
  int         mem_credit = DEPTH;
  int         cur_io_cfg = 0;
  int         cur_mem_cfg = 0;
  int         io_tkn_cnt = 0;
  int         mem_tkn_cnt = 0;
  int         checks = 0;
  int         errors = 0;

  tb_clock_gen clock_gen (.clk_o(clk), .rst_n_o(rst_n));

  link_chip uut
    (.clk_i(clk), .rst_n_i(rst_n), .tag_data_i(tag_data), .tag_en_i(tag_en)
    ,.io_link_v_i(io_v), .io_link_data_i(io_data), .io_link_tkn_o(io_tkn)
    ,.mem_link_v_i(mem_v), .mem_link_data_i(mem_data), .mem_link_tkn_o(mem_tkn)
    ,.core_v_o(core_v), .core_data_o(core_data), .core_src_o(core_src)
    ,.core_ready_i(core_ready)
    );

  bind link_chip link_chip_props props
    (.clk_i(clk_i), .rst_n_i(rst_n_i), .core_v_i(core_v_o), .core_data_i(core_data_o)
    ,.core_src_i(core_src_o), .core_ready_i(core_ready_i), .io_tkn_i(io_link_tkn_o)
    ,.mem_tkn_i(mem_link_tkn_o), .io_v_i(io_link_v_i), .mem_v_i(mem_link_v_i)
    ,.io_level_i(io_stream.level), .mem_level_i(mem_stream.level)
    );

  task automatic check_value(input string sig, input int exp, input int got);
    checks++;
    assert (exp == got)
    else
    begin
      $display("FAIL %s exp=%h got=%h", sig, exp, got);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string msg);
    checks++;
    assert (cond)
    else
    begin
      $display("%s", msg);
      errors++;
    end
  endtask

  function automatic int total_errors();
    return errors + uut.props.err_cnt;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Stimulus

  task automatic send_tag(input int id, input int payload);
    logic [`TAG_PAYLOAD_WIDTH+`TAG_ID_WIDTH:0] pkt;
    pkt = {tag_payload_t'(payload), tag_id_t'(id), 1'b1};
    for (int b = 0; b < $bits(pkt); b++)
    begin
      @(posedge clk);
      tag_en   <= 1'b1;
      tag_data <= pkt[b];
    end
    @(posedge clk);
    tag_en   <= 1'b0;
    tag_data <= 1'b0;
  endtask

  task automatic send_flit(input bit to_mem);
    link_data_t val;
    while ((to_mem ? mem_credit : io_credit) == 0)
    begin
      @(posedge clk);
      io_v  <= 1'b0;
      mem_v <= 1'b0;
    end
    val = link_data_t'($random(seed));
    @(posedge clk);
    io_v  <= !to_mem;
    mem_v <= to_mem;
    if (to_mem)
    begin
      mem_data <= val;
      mem_q.push_back(val);
      mem_credit--;
    end
    else
    begin
      io_data <= val;
      io_q.push_back(val);
      io_credit--;
    end
  endtask

  // Grant sequence for preloaded FIFOs with no new arrivals
  task automatic build_order(input int n_io, input int n_mem, input bit fuller);
    int        li;
    int        lm;
    link_src_e pick;
    li = n_io;
    lm = n_mem;
    while (li + lm > 0)
    begin
      if (li > 0 && lm > 0)
        pick = fuller ? ((lm > li) ? SRC_MEM : SRC_IO)
                      : ((rr_last == SRC_IO) ? SRC_MEM : SRC_IO);
      else
        pick = (lm > 0) ? SRC_MEM : SRC_IO;
      rr_last = pick;
      if (pick == SRC_IO)
        li--;
      else
        lm--;
      order_q.push_back(pick);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Core output and token monitor

  always @(posedge clk)
  begin
    link_data_t exp_data;
    if (rst_n)
    begin
      if (io_tkn)
      begin
        io_tkn_cnt++;
        io_credit += 1 << cur_io_cfg;
      end
      if (mem_tkn)
      begin
        mem_tkn_cnt++;
        mem_credit += 1 << cur_mem_cfg;
      end
      if (core_v && core_ready)
      begin
        if (check_order)
        begin
          check_true(order_q.size() > 0, "Core output flit beyond the expected sequence");
          if (order_q.size() > 0)
            check_value("core_src_o", order_q.pop_front(), core_src);
        end
        if (core_src == SRC_IO)
        begin
          check_true(io_q.size() > 0, "Core output io flit with none pending");
          if (io_q.size() > 0)
          begin
            exp_data = io_q.pop_front();
            check_value("core_data_o", exp_data, core_data);
          end
        end
        else
        begin
          check_true(mem_q.size() > 0, "Core output mem flit with none pending");
          if (mem_q.size() > 0)
          begin
            exp_data = mem_q.pop_front();
            check_value("core_data_o", exp_data, core_data);
          end
        end
      end
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles with flits still pending", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////
  // Test table and main loop

  initial
  begin
    int        err_before;
    test_row_t r;
    seed       = 95223;
    tag_data   = 1'b0;
    tag_en     = 1'b0;
    io_v       = 1'b0;
    io_data    = '0;
    mem_v      = 1'b0;
    mem_data   = '0;
    core_ready = 1'b1;
    // io_cfg mem_cfg merge n_io n_mem rand_ready model_order tag3
    rows[0] = '{2'd0, 2'd0, 3'b011, 4'd4, 4'd4, 1'b0, 1'b1, 1'b0};
    rows[1] = '{2'd1, 2'd1, 3'b111, 4'd6, 4'd2, 1'b0, 1'b1, 1'b0};
    rows[2] = '{2'd2, 2'd3, 3'b011, 4'd4, 4'd8, 1'b1, 1'b0, 1'b0};
    rows[3] = '{2'd2, 2'd0, 3'b011, 4'd8, 4'd5, 1'b1, 1'b0, 1'b1};
    rows[4] = '{2'd1, 2'd2, 3'b111, 4'd6, 4'd4, 1'b1, 1'b1, 1'b0};

    wait (rst_n === 1'b1);
    repeat (4)
    begin
      @(posedge clk);
      check_value("core_v_o", 0, core_v);
      check_value("io_link_tkn_o", 0, io_tkn);
      check_value("mem_link_tkn_o", 0, mem_tkn);
    end

    for (int i = 0; i < NUM_ROWS; i++)
    begin
      r          = rows[i];
      err_before = total_errors();
      send_tag(`TAG_CLIENT_MERGE, 0);
      send_tag(`TAG_CLIENT_IO, r.io_cfg);
      send_tag(`TAG_CLIENT_MEM, r.mem_cfg);
      cur_io_cfg  = r.io_cfg;
      cur_mem_cfg = r.mem_cfg;
      io_tkn_cnt  = 0;
      mem_tkn_cnt = 0;
      // Unused client leaves every register alone
      if (r.tag3)
        send_tag(3, 8'hff);
      for (int n = 0; n < r.n_io; n++)
        send_flit(1'b0);
      for (int n = 0; n < r.n_mem; n++)
        send_flit(1'b1);
      @(posedge clk);
      io_v  <= 1'b0;
      mem_v <= 1'b0;

      repeat (16)
      begin
        @(posedge clk);
        check_true(!core_v, "Flit reached the core output while both grants were off");
      end

      if (r.model_order)
        build_order(r.n_io, r.n_mem, r.merge_cfg[2]);
      check_order = r.model_order;
      send_tag(`TAG_CLIENT_MERGE, r.merge_cfg);
      while (io_q.size() + mem_q.size() > 0)
      begin
        @(posedge clk);
        core_ready <= r.rand_ready ? 1'($random(seed)) : 1'b1;
      end
      core_ready <= 1'b1;
      repeat (3) @(posedge clk);

      check_value("io_link_tkn_o pulses", r.n_io >> r.io_cfg, io_tkn_cnt);
      check_value("mem_link_tkn_o pulses", r.n_mem >> r.mem_cfg, mem_tkn_cnt);
      check_true(io_credit == DEPTH, "Io link credits were not all returned");
      check_true(mem_credit == DEPTH, "Mem link credits were not all returned");
      check_true(order_q.size() == 0, "Core output ended before the expected sequence");
      check_order = 1'b0;
      order_q.delete();
      $display("Test %0d io_cfg=%0d mem_cfg=%0d merge_cfg=%0d io=%0d mem=%0d: %s",
               i, r.io_cfg, r.mem_cfg, r.merge_cfg, r.n_io, r.n_mem,
               (total_errors() == err_before) ? "ok" : "errors");
    end

    $display("Tests %0d, checks %0d, errors %0d", NUM_ROWS, checks, total_errors());
    if (total_errors() == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/link_chip_props.sv */
`timescale 1ns/1ns
`default_nettype none

`include "link_chip_defines.svh"

module link_chip_props
  import link_chip_pkg::*;
 (input logic        clk_i
 ,input logic        rst_n_i
 ,input logic        core_v_i
 ,input link_data_t  core_data_i
 ,input link_src_e   core_src_i
 ,input logic        core_ready_i
 ,input logic        io_tkn_i
 ,input logic        mem_tkn_i
 ,input logic        io_v_i
 ,input logic        mem_v_i
 ,input fifo_level_t io_level_i
 ,input fifo_level_t mem_level_i
 );

  localparam fifo_level_t FULL = fifo_level_t'(1 << `LINK_LG_FIFO_DEPTH);

  int err_cnt = 0;

  // Stalled output holds its flit
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_v_i && !core_ready_i |=> core_v_i && $stable(core_data_i) && $stable(core_src_i))
  else
  begin
    err_cnt++;
    $error("core output changed while stalled");
  end

  assert property (@(posedge clk_i) !rst_n_i |=> !core_v_i && !io_tkn_i && !mem_tkn_i)
  else
  begin
    err_cnt++;
    $error("core valid or token high during reset");
  end

  // Sender must respect credits
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(io_v_i && io_level_i == FULL) && !(mem_v_i && mem_level_i == FULL))
  else
  begin
    err_cnt++;
    $error("flit sent into a full FIFO");
  end

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen
 (output logic clk_o
 ,output logic rst_n_o
 );

  // 8 ns period
  initial
  begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

/* hw/link_chip.sv */
`timescale 1ns/1ns
`default_nettype none

module link_chip
  import link_chip_pkg::*;
 (input  logic       clk_i
 ,input  logic       rst_n_i

 ,input  logic       tag_data_i
 ,input  logic       tag_en_i

 ,input  logic       io_link_v_i
 ,input  link_data_t io_link_data_i
 ,output logic       io_link_tkn_o

 ,input  logic       mem_link_v_i
 ,input  link_data_t mem_link_data_i
 ,output logic       mem_link_tkn_o

 ,output logic       core_v_o
 ,output link_data_t core_data_o
 ,output link_src_e  core_src_o
 ,input  logic       core_ready_i
 );

  ////////////////////////////////////////////////////////////////////
  // Tag master

  ep_cfg_t    io_cfg_lo;
  ep_cfg_t    mem_cfg_lo;
  merge_cfg_t merge_cfg_lo;

  tag_master btm
    (.clk_i      ( clk_i        )
    ,.rst_n_i    ( rst_n_i      )
    ,.tag_data_i ( tag_data_i   )
    ,.tag_en_i   ( tag_en_i     )
    ,.io_cfg_o   ( io_cfg_lo    )
    ,.mem_cfg_o  ( mem_cfg_lo   )
    ,.merge_cfg_o( merge_cfg_lo )
    );

  ////////////////////////////////////////////////////////////////////
  // Link endpoints

  link_stream_if io_stream ();
  link_stream_if mem_stream ();

  link_endpoint io_ep
    (.clk_i      ( clk_i          )
    ,.rst_n_i    ( rst_n_i        )
    ,.link_v_i   ( io_link_v_i    )
    ,.link_data_i( io_link_data_i )
    ,.link_tkn_o ( io_link_tkn_o  )
    ,.cfg_i      ( io_cfg_lo      )
    ,.stream     ( io_stream      )
    );

  link_endpoint mem_ep
    (.clk_i      ( clk_i           )
    ,.rst_n_i    ( rst_n_i         )
    ,.link_v_i   ( mem_link_v_i    )
    ,.link_data_i( mem_link_data_i )
    ,.link_tkn_o ( mem_link_tkn_o  )
    ,.cfg_i      ( mem_cfg_lo      )
    ,.stream     ( mem_stream      )
    );

  ////////////////////////////////////////////////////////////////////
  // Core side merge

  core_merge merge
    (.clk_i       ( clk_i        )
    ,.rst_n_i     ( rst_n_i      )
    ,.io_stream   ( io_stream    )
    ,.mem_stream  ( mem_stream   )
    ,.cfg_i       ( merge_cfg_lo )
    ,.core_v_o    ( core_v_o     )
    ,.core_data_o ( core_data_o  )
    ,.core_src_o  ( core_src_o   )
    ,.core_ready_i( core_ready_i )
    );

endmodule

`default_nettype wire

/* hw/core_merge.sv */
`timescale 1ns/1ns
`default_nettype none

module core_merge
  import link_chip_pkg::*;
 (input  logic       clk_i
 ,input  logic       rst_n_i
 ,link_stream_if.consumer io_stream
 ,link_stream_if.consumer mem_stream
 ,input  merge_cfg_t cfg_i
 ,output logic       core_v_o
 ,output link_data_t core_data_o
 ,output link_src_e  core_src_o
 ,input  logic       core_ready_i
 );

  logic       core_v_r;
  link_data_t core_data_r;
  link_src_e  core_src_r;
  link_src_e  last_r;
  logic       take;
  logic       io_req;
  logic       mem_req;
  logic       grant_v;
  link_src_e  grant_src;

  // Output slot is free or leaving this cycle
  assign take    = !core_v_r || core_ready_i;
  assign io_req  = io_stream.v && cfg_i[0];
  assign mem_req = mem_stream.v && cfg_i[1];
  assign grant_v = take && (io_req || mem_req);

  always_comb
  begin
    if (io_req && mem_req)
    begin
      if (cfg_i[2])
        grant_src = (mem_stream.level > io_stream.level) ? SRC_MEM : SRC_IO;
      else
        grant_src = (last_r == SRC_IO) ? SRC_MEM : SRC_IO;
    end
    else if (mem_req)
      grant_src = SRC_MEM;
    else
      grant_src = SRC_IO;
  end

  assign io_stream.yumi  = grant_v && (grant_src == SRC_IO);
  assign mem_stream.yumi = grant_v && (grant_src == SRC_MEM);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      core_v_r <= 1'b0;
      last_r   <= SRC_MEM;
    end
    else
    begin
      if (take)
        core_v_r <= grant_v;
      if (grant_v)
        last_r <= grant_src;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (grant_v)
    begin
      core_data_r <= (grant_src == SRC_MEM) ? mem_stream.data : io_stream.data;
      core_src_r  <= grant_src;
    end
  end

  assign core_v_o    = core_v_r;
  assign core_data_o = core_data_r;
  assign core_src_o  = core_src_r;

endmodule

`default_nettype wire

/* hw/link_endpoint.sv */
`timescale 1ns/1ns
`default_nettype none

`include "link_chip_defines.svh"

module link_endpoint
  import link_chip_pkg::*;
 (input  logic       clk_i
 ,input  logic       rst_n_i
 ,input  logic       link_v_i
 ,input  link_data_t link_data_i
 ,output logic       link_tkn_o
 ,input  ep_cfg_t    cfg_i
 ,link_stream_if.producer stream
 );

  link_data_t                      mem_r [0:(1<<`LINK_LG_FIFO_DEPTH)-1];
  logic [`LINK_LG_FIFO_DEPTH-1:0]  wr_ptr_r;
  logic [`LINK_LG_FIFO_DEPTH-1:0]  rd_ptr_r;
  fifo_level_t                     level_r;
  logic                            full;
  logic                            enq;
  logic                            deq;
  logic [`LINK_LG_FIFO_DEPTH:0]    deq_cnt_r;
  logic [`LINK_LG_FIFO_DEPTH:0]    deq_cnt_next;
  logic [`LINK_LG_FIFO_DEPTH:0]    group;
  logic                            tkn_r;

  ////////////////////////////////////////////////////////////////////
  // Flit FIFO

  assign full = (level_r == fifo_level_t'(1 << `LINK_LG_FIFO_DEPTH));
  assign enq  = link_v_i && !full;
  assign deq  = stream.yumi;

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wr_ptr_r] <= link_data_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      level_r  <= '0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (deq)
        rd_ptr_r <= rd_ptr_r + 1'b1;
      case ({enq, deq})
        2'b10:   level_r <= level_r + 1'b1;
        2'b01:   level_r <= level_r - 1'b1;
        default: level_r <= level_r;
      endcase
    end
  end

  assign stream.v     = (level_r != '0);
  assign stream.data  = mem_r[rd_ptr_r];
  assign stream.level = level_r;

  ////////////////////////////////////////////////////////////////////
  // Credit return with one token per group of dequeued flits

  assign group        = {{`LINK_LG_FIFO_DEPTH{1'b0}}, 1'b1} << cfg_i;
  assign deq_cnt_next = deq_cnt_r + 1'b1;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      deq_cnt_r <= '0;
      tkn_r     <= 1'b0;
    end
    else
    begin
      tkn_r <= 1'b0;
      if (deq)
      begin
        // Greater-or-equal covers a smaller setting written mid-group
        if (deq_cnt_next >= group)
        begin
          deq_cnt_r <= deq_cnt_next - group;
          tkn_r     <= 1'b1;
        end
        else
          deq_cnt_r <= deq_cnt_next;
      end
    end
  end

  assign link_tkn_o = tkn_r;

endmodule

`default_nettype wire

/* hw/tag_master.sv */
`timescale 1ns/1ns
`default_nettype none

`include "link_chip_defines.svh"

module tag_master
  import link_chip_pkg::*;
 (input  logic       clk_i
 ,input  logic       rst_n_i
 ,input  logic       tag_data_i
 ,input  logic       tag_en_i
 ,output ep_cfg_t    io_cfg_o
 ,output ep_cfg_t    mem_cfg_o
 ,output merge_cfg_t merge_cfg_o
 );

  tag_state_e   state_r;
  logic [2:0]   bit_cnt_r;
  tag_id_t      id_r;
  tag_payload_t payload_r;
  tag_payload_t payload_next;
  logic         last_bit;
  ep_cfg_t      io_cfg_r;
  ep_cfg_t      mem_cfg_r;
  merge_cfg_t   merge_cfg_r;

  // Fields arrive LSB first
  assign payload_next = {tag_data_i, payload_r[`TAG_PAYLOAD_WIDTH-1:1]};
  assign last_bit     = tag_en_i && (state_r == TAG_PAYLOAD)
                        && (bit_cnt_r == 3'(`TAG_PAYLOAD_WIDTH - 1));

  ////////////////////////////////////////////////////////////////////
  // Packet receiver

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_r   <= TAG_IDLE;
      bit_cnt_r <= '0;
    end
    else if (tag_en_i)
    begin
      case (state_r)
        TAG_IDLE:
          if (tag_data_i)
          begin
            state_r   <= TAG_ID;
            bit_cnt_r <= '0;
          end
        TAG_ID:
          if (bit_cnt_r == 3'(`TAG_ID_WIDTH - 1))
          begin
            state_r   <= TAG_PAYLOAD;
            bit_cnt_r <= '0;
          end
          else
            bit_cnt_r <= bit_cnt_r + 3'd1;
        TAG_PAYLOAD:
          if (last_bit)
          begin
            state_r   <= TAG_IDLE;
            bit_cnt_r <= '0;
          end
          else
            bit_cnt_r <= bit_cnt_r + 3'd1;
        default:
          state_r <= TAG_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (tag_en_i && (state_r == TAG_ID))
      id_r <= {tag_data_i, id_r[`TAG_ID_WIDTH-1:1]};
    if (tag_en_i && (state_r == TAG_PAYLOAD))
      payload_r <= payload_next;
  end

  ////////////////////////////////////////////////////////////////////
  // Client configuration registers

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      io_cfg_r    <= '0;
      mem_cfg_r   <= '0;
      merge_cfg_r <= '0;
    end
    else if (last_bit)
    begin
      case (id_r)
        tag_id_t'(`TAG_CLIENT_IO):    io_cfg_r    <= payload_next[$bits(ep_cfg_t)-1:0];
        tag_id_t'(`TAG_CLIENT_MEM):   mem_cfg_r   <= payload_next[$bits(ep_cfg_t)-1:0];
        tag_id_t'(`TAG_CLIENT_MERGE): merge_cfg_r <= payload_next[$bits(merge_cfg_t)-1:0];
        // Packets to unknown clients are dropped
        default: ;
      endcase
    end
  end

  assign io_cfg_o    = io_cfg_r;
  assign mem_cfg_o   = mem_cfg_r;
  assign merge_cfg_o = merge_cfg_r;

endmodule

`default_nettype wire

/* hw/link_stream_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Endpoint FIFO head toward the merge unit
interface link_stream_if
  import link_chip_pkg::*;
  ();

  logic        v;
  link_data_t  data;
  fifo_level_t level;
  logic        yumi;

  modport producer
    (output v, data, level
    ,input  yumi
    );

  modport consumer
    (input  v, data, level
    ,output yumi
    );

endinterface

`default_nettype wire

/* hw/link_chip_pkg.sv */
`default_nettype none

`include "link_chip_defines.svh"

package link_chip_pkg;

  typedef logic [`LINK_DATA_WIDTH-1:0]   link_data_t;
  typedef logic [`LINK_LG_FIFO_DEPTH:0]  fifo_level_t;
  typedef logic [`TAG_ID_WIDTH-1:0]      tag_id_t;
  typedef logic [`TAG_PAYLOAD_WIDTH-1:0] tag_payload_t;

  // Log2 of the credit to token decimation
  typedef logic [1:0] ep_cfg_t;

  // Bit 0 io grant, bit 1 mem grant, bit 2 fuller-first mode
  typedef logic [2:0] merge_cfg_t;

  typedef enum logic [1:0] {TAG_IDLE, TAG_ID, TAG_PAYLOAD} tag_state_e;

  typedef enum logic {SRC_IO = 1'b0, SRC_MEM = 1'b1} link_src_e;

endpackage

`default_nettype wire

/* hw/link_chip_defines.svh */
`ifndef LINK_CHIP_DEFINES_SVH
`define LINK_CHIP_DEFINES_SVH

// Link flit and endpoint FIFO
`define LINK_DATA_WIDTH     9
`define LINK_LG_FIFO_DEPTH  3

// Tag bus packet fields
`define TAG_ID_WIDTH        2
`define TAG_PAYLOAD_WIDTH   8

// Tag client numbers
// Client 3 has no register
`define TAG_CLIENT_IO       0
`define TAG_CLIENT_MEM      1
`define TAG_CLIENT_MERGE    2

`endif
